// File: flist.f
rtl/ray_pkg.sv
rtl/fifo_array.sv
rtl/dot.sv
rtl/plane_offset.sv
rtl/dir_dot.sv
rtl/divide_q.sv
rtl/ray_plane_hit.sv
tests/tb_ray_plane_hit.sv

// File: rtl/dir_dot.sv
module dir_dot #(
    parameter int DEPTH = 8
) (
    input  logic              clock,
    input  logic              rst_n,
    input  ray_pkg::ray_req_t req,
    input  logic              wr_en,
    output logic              full,
    output ray_pkg::coord_t   out,
    output logic              out_empty,
    input  logic              out_rd_en
);

    ray_pkg::ray_req_t head;
    ray_pkg::dot_pair_t dir_pair;
    logic head_empty;
    logic head_rd_en;

    fifo_array #(
        .DEPTH     (DEPTH),
        .payload_t (ray_pkg::ray_req_t)
    ) req_fifo (
        .clock     (clock),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .din       (req),
        .full      (full),
        .rd_en     (head_rd_en),
        .dout      (head),
        .empty     (head_empty)
    );

    assign dir_pair = '{a: head.normal, b: head.dir};

    dot u_dot (
        .clock     (clock),
        .rst_n     (rst_n),
        .operands  (dir_pair),
        .in_empty  (head_empty),
        .in_rd_en  (head_rd_en),
        .out       (out),
        .out_empty (out_empty),
        .out_rd_en (out_rd_en)
    );

endmodule

// File: rtl/divide_q.sv
module divide_q (
    input  logic            clock,
    input  logic            rst_n,
    input  ray_pkg::coord_t dividend,
    input  ray_pkg::coord_t divisor,
    input  logic            in_empty,
    output logic            in_rd_en,
    output ray_pkg::coord_t out,
    output logic            out_empty,
    input  logic            out_rd_en
);

    localparam int W = ray_pkg::COORD_BITS;
    localparam int N = ray_pkg::COORD_BITS + ray_pkg::FRAC_BITS;
    localparam int CNT_BITS = $clog2(N);
    localparam ray_pkg::coord_t COORD_MAX = {1'b0, {(W-1){1'b1}}};

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUSY,
        S_FINISH
    } state_t;

    state_t state;
    logic [CNT_BITS-1:0] count;
    logic [N-1:0] num;
    logic [N-1:0] signed_q;
    logic [W-1:0] rem;
    logic [W-1:0] den;
    logic [W:0] rem_shift;
    logic [W-1:0] dividend_mag;
    logic [W-1:0] divisor_mag;
    logic q_bit;
    logic negate;
    logic zero_div;
    logic out_valid;

    assign dividend_mag = dividend[W-1] ? -dividend : dividend;
    assign divisor_mag = divisor[W-1] ? -divisor : divisor;

    // one restoring step, num shifts out dividend bits and takes quotient bits
    assign rem_shift = {rem, num[N-1]};
    assign q_bit = rem_shift >= {1'b0, den};
    assign signed_q = negate ? -num : num;

    // output slot must be free by the time the result lands
    assign in_rd_en = !in_empty && state == S_IDLE && (!out_valid || out_rd_en);
    assign out_empty = !out_valid;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            count <= '0;
            out_valid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (in_rd_en) begin
                        state <= S_BUSY;
                        count <= '0;
                    end
                end
                S_BUSY: begin
                    count <= count + 1'b1;
                    if (count == CNT_BITS'(N - 1)) begin
                        state <= S_FINISH;
                    end
                end
                S_FINISH: state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
            out_valid <= (state == S_FINISH) || (out_valid && !out_rd_en);
        end
    end

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            num <= {dividend_mag, {ray_pkg::FRAC_BITS{1'b0}}};
            rem <= '0;
            den <= divisor_mag;
            negate <= dividend[W-1] ^ divisor[W-1];
            zero_div <= divisor == '0;
        end else if (state == S_BUSY) begin
            num <= {num[N-2:0], q_bit};
            rem <= q_bit ? W'(rem_shift - {1'b0, den}) : rem_shift[W-1:0];
        end
        // zero divisor saturates
        if (state == S_FINISH) begin
            out <= zero_div ? COORD_MAX : ray_pkg::coord_t'(signed_q);
        end
    end

    a_no_pop_busy: assert property (@(posedge clock) disable iff (!rst_n)
        !(in_rd_en && state != S_IDLE))
        else $error("divider popped while busy");

    a_latency: assert property (@(posedge clock) disable iff (!rst_n)
        in_rd_en |-> ##(N + 2) !out_empty)
        else $error("divider result late");

endmodule

// File: rtl/dot.sv
module dot (
    input  logic               clock,
    input  logic               rst_n,
    input  ray_pkg::dot_pair_t operands,
    input  logic               in_empty,
    output logic               in_rd_en,
    output ray_pkg::coord_t    out,
    output logic               out_empty,
    input  logic               out_rd_en
);

    typedef logic signed [2*ray_pkg::COORD_BITS-1:0] wide_t;

    wide_t prod_q [3];
    wide_t sum;
    logic prod_valid;
    logic out_valid;
    logic advance;

    // products move on once the output slot is free or being read
    assign advance = prod_valid && (!out_valid || out_rd_en);
    assign in_rd_en = !in_empty && (!prod_valid || advance);
    assign sum = prod_q[0] + prod_q[1] + prod_q[2];
    assign out_empty = !out_valid;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            prod_valid <= in_rd_en || (prod_valid && !advance);
            out_valid <= advance || (out_valid && !out_rd_en);
        end
    end

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            prod_q[0] <= wide_t'(operands.a.x) * wide_t'(operands.b.x);
            prod_q[1] <= wide_t'(operands.a.y) * wide_t'(operands.b.y);
            prod_q[2] <= wide_t'(operands.a.z) * wide_t'(operands.b.z);
        end
        // back to Q format, low word kept
        if (advance) begin
            out <= ray_pkg::coord_t'(sum >>> ray_pkg::FRAC_BITS);
        end
    end

    a_pop_needs_data: assert property (@(posedge clock) disable iff (!rst_n)
        in_rd_en |-> !in_empty)
        else $error("dot pop while input empty");

endmodule

// File: rtl/fifo_array.sv
module fifo_array #(
    parameter int DEPTH = 8,
    parameter type payload_t = logic [31:0]
) (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     wr_en,
    input  payload_t din,
    output logic     full,
    input  logic     rd_en,
    output payload_t dout,
    output logic     empty
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic push;
    logic pop;

    assign push = wr_en && !full;
    assign pop = rd_en && !empty;
    assign full = count == CNT_BITS'(DEPTH);
    assign empty = count == '0;
    // show-ahead head
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clock) disable iff (!rst_n)
        wr_en |-> !full)
        else $error("fifo write while full");

    a_no_underflow: assert property (@(posedge clock) disable iff (!rst_n)
        rd_en |-> !empty)
        else $error("fifo read while empty");

endmodule

// File: rtl/plane_offset.sv
module plane_offset #(
    parameter int DEPTH = 8
) (
    input  logic                clock,
    input  logic                rst_n,
    input  ray_pkg::plane_req_t req,
    input  logic                wr_en,
    output logic                full,
    output ray_pkg::coord_t     out,
    output logic                out_empty,
    input  logic                out_rd_en
);

    ray_pkg::plane_req_t head;
    ray_pkg::dot_pair_t v0_pair;
    ray_pkg::dot_pair_t origin_pair;
    ray_pkg::coord_t n_v0;
    ray_pkg::coord_t n_origin;
    logic head_empty;
    logic head_rd_en;
    logic v0_rd_en;
    logic origin_rd_en;
    logic v0_empty;
    logic origin_empty;
    logic sub_rd_en;
    logic out_valid;

    fifo_array #(
        .DEPTH     (DEPTH),
        .payload_t (ray_pkg::plane_req_t)
    ) req_fifo (
        .clock     (clock),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .din       (req),
        .full      (full),
        .rd_en     (head_rd_en),
        .dout      (head),
        .empty     (head_empty)
    );

    assign v0_pair = '{a: head.normal, b: head.v0};
    assign origin_pair = '{a: head.normal, b: head.origin};
    // both dots see the same head, so their pops match
    assign head_rd_en = v0_rd_en || origin_rd_en;

    dot normal_v0_dot (
        .clock     (clock),
        .rst_n     (rst_n),
        .operands  (v0_pair),
        .in_empty  (head_empty),
        .in_rd_en  (v0_rd_en),
        .out       (n_v0),
        .out_empty (v0_empty),
        .out_rd_en (sub_rd_en)
    );

    dot normal_origin_dot (
        .clock     (clock),
        .rst_n     (rst_n),
        .operands  (origin_pair),
        .in_empty  (head_empty),
        .in_rd_en  (origin_rd_en),
        .out       (n_origin),
        .out_empty (origin_empty),
        .out_rd_en (sub_rd_en)
    );

    // subtract slot
    assign sub_rd_en = !v0_empty && !origin_empty && (!out_valid || out_rd_en);
    assign out_empty = !out_valid;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= sub_rd_en || (out_valid && !out_rd_en);
        end
    end

    always_ff @(posedge clock) begin
        if (sub_rd_en) begin
            out <= n_v0 - n_origin;
        end
    end

endmodule

// File: rtl/ray_pkg.sv
package ray_pkg;

    // Q16.16 words
    parameter int COORD_BITS = 32;
    parameter int FRAC_BITS = 16;

    typedef logic signed [COORD_BITS-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vec3_t;

    // plane channel operands for n.v0 - n.origin
    typedef struct packed {
        vec3_t normal;
        vec3_t v0;
        vec3_t origin;
    } plane_req_t;

    // ray channel operands for n.dir
    typedef struct packed {
        vec3_t normal;
        vec3_t dir;
    } ray_req_t;

    // what one dot stage consumes
    typedef struct packed {
        vec3_t a;
        vec3_t b;
    } dot_pair_t;

endpackage

// File: rtl/ray_plane_hit.sv
module ray_plane_hit #(
    parameter int DEPTH = 8
) (
    input  logic                clock,
    input  logic                rst_n,
    input  ray_pkg::plane_req_t plane_req,
    input  logic                plane_wr_en,
    output logic                plane_full,
    input  ray_pkg::ray_req_t   ray_req,
    input  logic                ray_wr_en,
    output logic                ray_full,
    output ray_pkg::coord_t     hit_t,
    output logic                hit_empty,
    input  logic                hit_rd_en
);

    ray_pkg::coord_t offset;
    ray_pkg::coord_t denom;
    logic offset_empty;
    logic denom_empty;
    logic div_empty;
    logic div_rd_en;

    plane_offset #(
        .DEPTH     (DEPTH)
    ) u_plane_offset (
        .clock     (clock),
        .rst_n     (rst_n),
        .req       (plane_req),
        .wr_en     (plane_wr_en),
        .full      (plane_full),
        .out       (offset),
        .out_empty (offset_empty),
        .out_rd_en (div_rd_en)
    );

    dir_dot #(
        .DEPTH     (DEPTH)
    ) u_dir_dot (
        .clock     (clock),
        .rst_n     (rst_n),
        .req       (ray_req),
        .wr_en     (ray_wr_en),
        .full      (ray_full),
        .out       (denom),
        .out_empty (denom_empty),
        .out_rd_en (div_rd_en)
    );

    // both branches pop together so plane k meets ray k
    assign div_empty = offset_empty || denom_empty;

    divide_q u_divide_q (
        .clock     (clock),
        .rst_n     (rst_n),
        .dividend  (offset),
        .divisor   (denom),
        .in_empty  (div_empty),
        .in_rd_en  (div_rd_en),
        .out       (hit_t),
        .out_empty (hit_empty),
        .out_rd_en (hit_rd_en)
    );

endmodule

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ray_plane_hit \
    -f flist.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1

// File: tests/tb_ray_plane_hit.sv
module tb_ray_plane_hit;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = 8;
    localparam int TABLE_LEN = 8;
    localparam int NUM_RANDOM = 24;
    localparam int BP_LIMIT = 24;
    localparam ray_pkg::coord_t ONE = 32'h0001_0000;
    localparam ray_pkg::coord_t HALF = 32'h0000_8000;
    localparam ray_pkg::coord_t COORD_MAX = {1'b0, {(ray_pkg::COORD_BITS-1){1'b1}}};
    localparam longint WATCHDOG_NS = longint'(2 * TABLE_LEN + BP_LIMIT + NUM_RANDOM)
        * longint'(ray_pkg::COORD_BITS + ray_pkg::FRAC_BITS + 20) * 40 + 400;

    logic clock;
    logic rst_n;
    ray_pkg::plane_req_t plane_req;
    logic plane_wr_en;
    logic plane_full;
    ray_pkg::ray_req_t ray_req;
    logic ray_wr_en;
    logic ray_full;
    ray_pkg::coord_t hit_t;
    logic hit_empty;
    logic hit_rd_en;

    ray_pkg::plane_req_t plane_tab [TABLE_LEN];
    ray_pkg::ray_req_t ray_tab [TABLE_LEN];
    ray_pkg::coord_t hit_tab [TABLE_LEN];
    ray_pkg::coord_t expected [$];
    integer seed = 32'ha207eee4;
    int error_count = 0;
    // 0 reads at once, 1 holds off, 2 reads at random
    int read_mode = 0;

    ray_plane_hit #(
        .DEPTH       (DEPTH)
    ) i_ray_plane_hit (
        .clock       (clock),
        .rst_n       (rst_n),
        .plane_req   (plane_req),
        .plane_wr_en (plane_wr_en),
        .plane_full  (plane_full),
        .ray_req     (ray_req),
        .ray_wr_en   (ray_wr_en),
        .ray_full    (ray_full),
        .hit_t       (hit_t),
        .hit_empty   (hit_empty),
        .hit_rd_en   (hit_rd_en)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic abort_run(input string line);
        error_count++;
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_hit(input ray_pkg::coord_t got, input ray_pkg::coord_t exp,
                             input string what);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %h expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %b expected %b",
                                $time, what, got, exp));
        end
    endtask

    function automatic ray_pkg::vec3_t make_vec(input ray_pkg::coord_t x,
                                                input ray_pkg::coord_t y,
                                                input ray_pkg::coord_t z);
        return '{x: x, y: y, z: z};
    endfunction

    function automatic ray_pkg::coord_t dot_q(input ray_pkg::vec3_t a, input ray_pkg::vec3_t b);
        longint sum;
        sum = longint'(a.x) * longint'(b.x) + longint'(a.y) * longint'(b.y)
            + longint'(a.z) * longint'(b.z);
        return ray_pkg::coord_t'(sum >>> ray_pkg::FRAC_BITS);
    endfunction

    task automatic model_hit(input ray_pkg::plane_req_t p, input ray_pkg::ray_req_t r,
                             output ray_pkg::coord_t t);
        longint num;
        longint den;
        longint q;
        num = longint'(dot_q(p.normal, p.v0) - dot_q(p.normal, p.origin));
        den = longint'(dot_q(r.normal, r.dir));
        if (den == 0) begin
            t = COORD_MAX;
        end else begin
            q = ((num < 0 ? -num : num) <<< ray_pkg::FRAC_BITS) / (den < 0 ? -den : den);
            if ((num < 0) != (den < 0)) begin
                q = -q;
            end
            t = ray_pkg::coord_t'(q);
        end
    endtask

    task automatic random_vec(output ray_pkg::vec3_t v);
        // components stay within about one unit
        v.x = ray_pkg::coord_t'(($random(seed) % 512) * 128);
        v.y = ray_pkg::coord_t'(($random(seed) % 512) * 128);
        v.z = ray_pkg::coord_t'(($random(seed) % 512) * 128);
    endtask

    task automatic set_row(input int idx, input ray_pkg::vec3_t nrm, input ray_pkg::vec3_t pv0,
                           input ray_pkg::vec3_t org, input ray_pkg::vec3_t dir,
                           input ray_pkg::coord_t t);
        plane_tab[idx] = '{normal: nrm, v0: pv0, origin: org};
        ray_tab[idx] = '{normal: nrm, dir: dir};
        hit_tab[idx] = t;
    endtask

    task automatic fill_table();
        ray_pkg::vec3_t zero;
        zero = make_vec(0, 0, 0);
        set_row(0, make_vec(0, 0, ONE), make_vec(0, 0, 10 * ONE), zero,
                make_vec(0, 0, 2 * ONE), 32'h0005_0000);
        set_row(1, make_vec(0, 0, ONE), make_vec(0, 0, -6 * ONE), zero,
                make_vec(0, 0, 2 * ONE), 32'hfffd_0000);
        set_row(2, make_vec(ONE, 0, 0), make_vec(ONE, 0, 0), zero,
                make_vec(4 * ONE, 0, 0), 32'h0000_4000);
        // parallel ray
        set_row(3, make_vec(0, ONE, 0), make_vec(0, 3 * ONE, 0), zero,
                make_vec(ONE, 0, 0), COORD_MAX);
        set_row(4, make_vec(0, 0, ONE), make_vec(0, 0, ONE), zero,
                make_vec(0, 0, 3 * ONE), 32'h0000_5555);
        set_row(5, make_vec(0, 0, ONE), zero, make_vec(0, 0, ONE),
                make_vec(0, 0, 3 * ONE), 32'hffff_aaab);
        set_row(6, make_vec(0, 0, ONE), make_vec(0, 0, 5 * ONE), make_vec(0, 0, ONE),
                make_vec(0, 0, -2 * ONE), 32'hfffe_0000);
        set_row(7, make_vec(0, 0, ONE + HALF), make_vec(0, 0, 2 * ONE), make_vec(0, 0, HALF),
                make_vec(0, 0, HALF), 32'h0003_0000);
    endtask

    task automatic write_req(input logic do_plane, input logic do_ray,
                             input ray_pkg::plane_req_t p, input ray_pkg::ray_req_t r);
        while ((do_plane && plane_full) || (do_ray && ray_full)) begin
            @(negedge clock);
        end
        plane_req = p;
        ray_req = r;
        plane_wr_en = do_plane;
        ray_wr_en = do_ray;
        @(negedge clock);
        plane_wr_en = 1'b0;
        ray_wr_en = 1'b0;
    endtask

    task automatic drain_results();
        while (expected.size() != 0) begin
            @(negedge clock);
        end
        @(negedge clock);
        check_flag(hit_empty, 1'b1, "hit_empty after drain");
    endtask

    // consumer, pops one result per read and compares it in issue order
    initial begin : reader
        ray_pkg::coord_t exp_t;
        hit_rd_en = 1'b0;
        forever begin
            @(negedge clock);
            hit_rd_en = 1'b0;
            if (rst_n && !hit_empty && (read_mode == 0
                    || (read_mode == 2 && ($random(seed) & 1) != 0))) begin
                if (expected.size() == 0) begin
                    abort_run("a result came out that no request accounts for");
                end
                exp_t = expected.pop_front();
                check_hit(hit_t, exp_t, "hit_t");
                hit_rd_en = 1'b1;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run("timeout: the expected results did not all arrive");
    end

    initial begin : main
        ray_pkg::plane_req_t p;
        ray_pkg::ray_req_t r;
        ray_pkg::coord_t t;
        int n;
        rst_n = 1'b0;
        plane_req = '0;
        ray_req = '0;
        plane_wr_en = 1'b0;
        ray_wr_en = 1'b0;
        fill_table();
        repeat (5) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);
        check_flag(hit_empty, 1'b1, "hit_empty after reset");
        check_flag(plane_full, 1'b0, "plane_full after reset");
        check_flag(ray_full, 1'b0, "ray_full after reset");

        for (int i = 0; i < TABLE_LEN; i++) begin
            expected.push_back(hit_tab[i]);
            write_req(1'b1, 1'b1, plane_tab[i], ray_tab[i]);
        end
        drain_results();

        // skewed channels, every plane ahead of every ray
        for (int i = 0; i < TABLE_LEN; i++) begin
            expected.push_back(hit_tab[i]);
            write_req(1'b1, 1'b0, plane_tab[i], ray_tab[i]);
        end
        for (int i = 0; i < TABLE_LEN; i++) begin
            write_req(1'b0, 1'b1, plane_tab[i], ray_tab[i]);
        end
        drain_results();

        // back-pressure until an input FIFO fills
        read_mode = 1;
        n = 0;
        while (!(plane_full || ray_full)) begin
            if (n == BP_LIMIT) begin
                abort_run("neither input FIFO became full while results were held");
            end
            expected.push_back(hit_tab[n % TABLE_LEN]);
            write_req(1'b1, 1'b1, plane_tab[n % TABLE_LEN], ray_tab[n % TABLE_LEN]);
            n++;
        end
        // held result keeps the inputs full
        while (hit_empty) begin
            @(negedge clock);
        end
        check_flag(plane_full || ray_full, 1'b1, "input full while held");
        read_mode = 0;
        drain_results();

        read_mode = 2;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_vec(p.normal);
            random_vec(p.v0);
            random_vec(p.origin);
            r.normal = p.normal;
            random_vec(r.dir);
            model_hit(p, r, t);
            expected.push_back(t);
            write_req(1'b1, 1'b1, p, r);
            repeat ($random(seed) & 3) @(negedge clock);
        end
        drain_results();
        check_flag(plane_full, 1'b0, "plane_full at end");
        check_flag(ray_full, 1'b0, "ray_full at end");

        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
